// ==== verilog.f ====
hw/obi_pkg.sv
hw/core_evt_pkg.sv
hw/obi_phases_monitor.sv
hw/req_attribute_fifo.sv
hw/obi_bus_support.sv
hw/debug_event_monitor.sv
hw/support_logic_top.sv
dv/support_logic_sva.sv
dv/tb_support_logic.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_support_logic
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/tb_support_logic.sv ====
`timescale 1ns/1ps

module tb_support_logic;

  import obi_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int BUS_TXN     = 48;
  localparam int RAND_CYC    = 60;
  // bus tests run twice, directed core sequences are short
  localparam int TEST_CYCLES = 2 * BUS_TXN * 12 + 16 + 2 * (16 + RAND_CYC);
  localparam int MARGIN_CYC  = 200;

  localparam int ST_NORMAL    = 0;
  localparam int ST_IN_DEBUG  = 1;
  localparam int ST_DRET_SEEN = 2;
  localparam int WIN_RETIRE   = 1;
  localparam int WIN_IDLE     = 2;

  logic        clk;
  logic        rst_n;

  // index 0 is the instruction bus, index 1 the data bus
  logic        bus_req    [2];
  logic        bus_gnt    [2];
  logic        bus_gntpar [2];
  logic        bus_rvalid [2];
  logic [31:0] bus_attr   [2];

  logic        fetch_en;
  logic        dbg_req;
  logic        rvfi_valid;
  logic        rvfi_dbg;
  logic        rvfi_dret;
  logic        rvfi_trap;

  logic        addr_cont  [2];
  logic        resp_cont  [2];
  obi_cnt_t    cnt_out    [2];
  logic        gntpar_err [2];
  logic [31:0] resp_pc;
  logic        resp_store;
  logic        first_fetch;
  logic        first_dbg;
  logic        rec_dbg;

  // reference model state
  int          m_cnt    [2];
  logic        m_wait   [2];
  // faulty cycles seen so far in the open address phase
  int          m_faults [2];
  logic [31:0] m_attr   [2][8];
  logic        m_err    [2][8];
  int          m_wr     [2];
  int          m_rd     [2];
  logic        m_fetch_seen;
  int          m_state;
  logic        m_rec;
  int          m_win;

  int          seed     = 32'hc802_02f3;
  int          n_checks = 0;
  int          n_errors = 0;

  support_logic_top u_dut (
    .in_support_if         (clk),
    .rst_n_i               (rst_n),
    .instr_bus_req_i       (bus_req[0]),
    .instr_bus_gnt_i       (bus_gnt[0]),
    .instr_bus_gntpar_i    (bus_gntpar[0]),
    .instr_bus_rvalid_i    (bus_rvalid[0]),
    .instr_req_pc_i        (bus_attr[0]),
    .data_bus_req_i        (bus_req[1]),
    .data_bus_gnt_i        (bus_gnt[1]),
    .data_bus_gntpar_i     (bus_gntpar[1]),
    .data_bus_rvalid_i     (bus_rvalid[1]),
    .data_req_is_store_i   (bus_attr[1][0]),
    .fetch_enable_i        (fetch_en),
    .debug_req_i           (dbg_req),
    .rvfi_valid_i          (rvfi_valid),
    .rvfi_dbg_mode_i       (rvfi_dbg),
    .rvfi_is_dret_i        (rvfi_dret),
    .rvfi_trap_i           (rvfi_trap),
    .instr_addr_ph_cont_o  (addr_cont[0]),
    .instr_resp_ph_cont_o  (resp_cont[0]),
    .instr_v_addr_ph_cnt_o (cnt_out[0]),
    .instr_gntpar_err_o    (gntpar_err[0]),
    .instr_resp_pc_o       (resp_pc),
    .data_addr_ph_cont_o   (addr_cont[1]),
    .data_resp_ph_cont_o   (resp_cont[1]),
    .data_v_addr_ph_cnt_o  (cnt_out[1]),
    .data_gntpar_err_o     (gntpar_err[1]),
    .data_req_was_store_o  (resp_store),
    .first_fetch_o         (first_fetch),
    .first_debug_ins_o     (first_dbg),
    .recorded_dbg_req_o    (rec_dbg)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // reference functions
  // ----------------------------------------------------------------------

  // a requesting cycle is faulty when gntpar fails to invert gnt
  function automatic logic gntpar_bad(input logic gnt, input logic gntpar);
    return gntpar !== ~gnt;
  endfunction

  function automatic int next_dbg_state(input int st, input logic valid, input logic dbg,
                                        input logic dret, input logic trap);
    int nxt;
    nxt = st;
    if (st == ST_NORMAL && valid && dbg) begin
      nxt = ST_IN_DEBUG;
    end else if (st == ST_IN_DEBUG && valid && !dbg) begin
      nxt = ST_NORMAL;
    end else if (st == ST_DRET_SEEN) begin
      nxt = ST_NORMAL;
    end
    if (valid && dret && !trap) begin
      nxt = ST_DRET_SEEN;
    end
    return nxt;
  endfunction

  function automatic logic exp_first_dbg(input int st, input logic valid, input logic dbg);
    return valid & dbg & (st != ST_IN_DEBUG);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // compare process, inputs and outputs are stable at the falling edge
  // ----------------------------------------------------------------------

  always @(negedge clk) begin : compare_outputs
    logic [31:0] got_attr;
    logic [31:0] push_attr;
    string       pfx;
    string       attr_name;
    for (int b = 0; b < 2; b++) begin
      pfx       = (b == 0) ? "instr_" : "data_";
      attr_name = (b == 0) ? "instr_resp_pc_o" : "data_req_was_store_o";
      got_attr  = (b == 0) ? resp_pc : {31'b0, resp_store};
      push_attr = (b == 0) ? bus_attr[0] : {31'b0, bus_attr[1][0]};
      if (rst_n) begin
        check_val({pfx, "addr_ph_cont_o"}, 32'(addr_cont[b]), 32'(m_wait[b] & bus_req[b]));
        check_val({pfx, "v_addr_ph_cnt_o"}, 32'(cnt_out[b]), m_cnt[b]);
        check_val({pfx, "resp_ph_cont_o"}, 32'(resp_cont[b]),
                  32'((m_cnt[b] != 0) & !bus_rvalid[b]));
        if (bus_rvalid[b]) begin
          check_val(attr_name, got_attr, m_attr[b][m_rd[b]]);
          check_val({pfx, "gntpar_err_o"}, 32'(gntpar_err[b]), 32'(m_err[b][m_rd[b]]));
        end
      end
      if (!rst_n) begin
        m_cnt[b]    = 0;
        m_wait[b]   = 1'b0;
        m_faults[b] = 0;
        m_wr[b]     = 0;
        m_rd[b]     = 0;
      end else begin
        if (bus_req[b] && gntpar_bad(bus_gnt[b], bus_gntpar[b])) begin
          m_faults[b]++;
        end
        if (bus_req[b] && bus_gnt[b]) begin
          m_attr[b][m_wr[b]] = push_attr;
          m_err[b][m_wr[b]]  = (m_faults[b] != 0);
          m_wr[b]            = (m_wr[b] + 1) % 8;
          m_faults[b]        = 0;
          m_cnt[b]++;
        end
        if (bus_rvalid[b]) begin
          m_rd[b] = (m_rd[b] + 1) % 8;
          m_cnt[b]--;
        end
        m_wait[b] = bus_req[b] & !bus_gnt[b];
      end
    end

    if (rst_n) begin
      check_val("first_fetch_o", 32'(first_fetch), 32'(fetch_en & !m_fetch_seen));
      check_val("first_debug_ins_o", 32'(first_dbg),
                32'(exp_first_dbg(m_state, rvfi_valid, rvfi_dbg)));
      check_val("recorded_dbg_req_o", 32'(rec_dbg), 32'(m_rec));
    end
    if (!rst_n) begin
      m_fetch_seen = 1'b0;
      m_state      = ST_NORMAL;
      m_rec        = 1'b0;
      m_win        = 0;
    end else begin
      m_fetch_seen = m_fetch_seen | fetch_en;
      m_state      = next_dbg_state(m_state, rvfi_valid, rvfi_dbg, rvfi_dret, rvfi_trap);
      if (dbg_req) begin
        m_rec = 1'b1;
        m_win = rvfi_valid ? WIN_RETIRE : WIN_IDLE;
      end else if (rvfi_valid) begin
        if (m_win != 0) begin
          m_win--;
        end else begin
          m_rec = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  // acts as both requester and memory of one bus
  task automatic run_bus(input int b, input int n_req, input int fault_lvl);
    int          issued;
    int          owed;
    logic        in_phase;
    logic        req_v;
    logic        gnt_v;
    logic        rv_v;
    logic        fault;
    logic [31:0] rnd;
    issued   = 0;
    owed     = 0;
    in_phase = 1'b0;
    while (issued < n_req || owed > 0) begin
      @(posedge clk);
      rnd   = $random(seed);
      req_v = in_phase | ((issued < n_req) & (owed < MAX_OUTSTANDING) & rnd[0]);
      gnt_v = req_v & rnd[1];
      rv_v  = (owed > 0) & rnd[4];
      fault = req_v & (rnd[11:8] < 4'(fault_lvl));
      if (req_v && !in_phase) begin
        bus_attr[b] <= $random(seed);
      end
      bus_req[b]    <= req_v;
      bus_gnt[b]    <= gnt_v;
      bus_gntpar[b] <= fault ? gnt_v : ~gnt_v;
      bus_rvalid[b] <= rv_v;
      if (req_v && gnt_v) begin
        issued++;
        owed++;
      end
      if (rv_v) begin
        owed--;
      end
      in_phase = req_v & !gnt_v;
    end
    @(posedge clk);
    bus_req[b]    <= 1'b0;
    bus_gnt[b]    <= 1'b0;
    bus_gntpar[b] <= 1'b1;
    bus_rvalid[b] <= 1'b0;
  endtask

  task automatic core_cycle(input logic dreq, input logic valid, input logic dbg,
                            input logic dret, input logic trap);
    @(posedge clk);
    dbg_req    <= dreq;
    rvfi_valid <= valid;
    rvfi_dbg   <= dbg;
    rvfi_dret  <= dret;
    rvfi_trap  <= trap;
  endtask

  task automatic random_core(input int n_cyc);
    logic [31:0] rnd;
    for (int i = 0; i < n_cyc; i++) begin
      rnd = $random(seed);
      core_cycle(rnd[3:0] == 4'd0, rnd[4], rnd[5], rnd[7:6] == 2'd0, rnd[8] & rnd[9]);
    end
    core_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic report_test(input string name, input int err_mark);
    @(negedge clk);
    #1;
    $display("test %-34s done, %0d errors", name, n_errors - err_mark);
  endtask

  initial begin : run_tests
    int err_mark;
    rst_n = 1'b0;
    for (int b = 0; b < 2; b++) begin
      bus_req[b]    = 1'b0;
      bus_gnt[b]    = 1'b0;
      bus_gntpar[b] = 1'b1;
      bus_rvalid[b] = 1'b0;
      bus_attr[b]   = '0;
    end
    fetch_en   = 1'b0;
    dbg_req    = 1'b0;
    rvfi_valid = 1'b0;
    rvfi_dbg   = 1'b0;
    rvfi_dret  = 1'b0;
    rvfi_trap  = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    err_mark = n_errors;
    fork
      run_bus(0, BUS_TXN, 0);
      run_bus(1, BUS_TXN, 0);
    join
    report_test("outstanding count and attributes", err_mark);

    err_mark = n_errors;
    fork
      run_bus(0, BUS_TXN, 3);
      run_bus(1, BUS_TXN, 3);
    join
    report_test("grant parity", err_mark);

    // fetch enable toggles, only its first rise counts
    err_mark = n_errors;
    repeat (3) @(posedge clk);
    fetch_en <= 1'b1;
    @(posedge clk);
    fetch_en <= 1'b0;
    repeat (2) @(posedge clk);
    fetch_en <= 1'b1;
    repeat (4) @(posedge clk);
    report_test("first fetch", err_mark);

    err_mark = n_errors;
    core_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b1);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
    core_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    random_core(RAND_CYC);
    report_test("first debug instruction", err_mark);

    err_mark = n_errors;
    core_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (3) core_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    repeat (2) core_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    core_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    random_core(RAND_CYC);
    report_test("recorded debug request", err_mark);

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #((TEST_CYCLES + MARGIN_CYC) * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== dv/support_logic_sva.sv ====
`timescale 1ns/1ps

module obi_phases_sva (
  input logic              in_support_if,
  input logic              rst_n_i,
  input logic              req_i,
  input logic              rvalid_i,
  input logic              addr_ph_cont_i,
  input obi_pkg::obi_cnt_t cnt_i
);

  import obi_pkg::*;

  // ----------------------------------------------------------------------
  // outstanding counter bounds
  // ----------------------------------------------------------------------

  a_cnt_max : assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    cnt_i <= CNT_W'(MAX_OUTSTANDING))
    else $error("outstanding count above the bus limit");

  // a response with nothing outstanding would wrap the counter
  a_cnt_underflow : assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    rvalid_i |-> cnt_i != '0)
    else $error("response seen with no outstanding request");

  // ----------------------------------------------------------------------
  // address phase continuation
  // ----------------------------------------------------------------------

  a_cont_has_req : assert property (@(posedge in_support_if) disable iff (!rst_n_i)
    addr_ph_cont_i |-> req_i)
    else $error("address phase continues without a request");

endmodule

bind obi_phases_monitor obi_phases_sva u_sva (
  .in_support_if  (in_support_if),
  .rst_n_i        (rst_n_i),
  .req_i          (req_i),
  .rvalid_i       (rvalid_i),
  .addr_ph_cont_i (addr_ph_cont_o),
  .cnt_i          (v_addr_ph_cnt_o)
);

// ==== hw/support_logic_top.sv ====
`timescale 1ns/1ps

module support_logic_top (
  input  logic                in_support_if,
  input  logic                rst_n_i,

  // instruction bus
  input  logic                instr_bus_req_i,
  input  logic                instr_bus_gnt_i,
  input  logic                instr_bus_gntpar_i,
  input  logic                instr_bus_rvalid_i,
  input  obi_pkg::obi_addr_t  instr_req_pc_i,

  // data bus
  input  logic                data_bus_req_i,
  input  logic                data_bus_gnt_i,
  input  logic                data_bus_gntpar_i,
  input  logic                data_bus_rvalid_i,
  input  logic                data_req_is_store_i,

  // core events
  input  logic                fetch_enable_i,
  input  logic                debug_req_i,
  input  logic                rvfi_valid_i,
  input  logic                rvfi_dbg_mode_i,
  input  logic                rvfi_is_dret_i,
  input  logic                rvfi_trap_i,

  output logic                instr_addr_ph_cont_o,
  output logic                instr_resp_ph_cont_o,
  output obi_pkg::obi_cnt_t   instr_v_addr_ph_cnt_o,
  output logic                instr_gntpar_err_o,
  output obi_pkg::obi_addr_t  instr_resp_pc_o,

  output logic                data_addr_ph_cont_o,
  output logic                data_resp_ph_cont_o,
  output obi_pkg::obi_cnt_t   data_v_addr_ph_cnt_o,
  output logic                data_gntpar_err_o,
  output logic                data_req_was_store_o,

  output logic                first_fetch_o,
  output logic                first_debug_ins_o,
  output logic                recorded_dbg_req_o
);

  import obi_pkg::*;

  // ----------------------------------------------------------------------
  // bus support, fetch PC rides along the instruction bus
  // ----------------------------------------------------------------------

  obi_bus_support #(
    .ATTR_W (ADDR_W)
  ) u_instr_bus (
    .in_support_if   (in_support_if),
    .rst_n_i         (rst_n_i),
    .req_i           (instr_bus_req_i),
    .gnt_i           (instr_bus_gnt_i),
    .gntpar_i        (instr_bus_gntpar_i),
    .rvalid_i        (instr_bus_rvalid_i),
    .attr_i          (instr_req_pc_i),
    .addr_ph_cont_o  (instr_addr_ph_cont_o),
    .resp_ph_cont_o  (instr_resp_ph_cont_o),
    .v_addr_ph_cnt_o (instr_v_addr_ph_cnt_o),
    .attr_o          (instr_resp_pc_o),
    .gntpar_err_o    (instr_gntpar_err_o)
  );

  // store flag rides along the data bus
  obi_bus_support #(
    .ATTR_W (1)
  ) u_data_bus (
    .in_support_if   (in_support_if),
    .rst_n_i         (rst_n_i),
    .req_i           (data_bus_req_i),
    .gnt_i           (data_bus_gnt_i),
    .gntpar_i        (data_bus_gntpar_i),
    .rvalid_i        (data_bus_rvalid_i),
    .attr_i          (data_req_is_store_i),
    .addr_ph_cont_o  (data_addr_ph_cont_o),
    .resp_ph_cont_o  (data_resp_ph_cont_o),
    .v_addr_ph_cnt_o (data_v_addr_ph_cnt_o),
    .attr_o          (data_req_was_store_o),
    .gntpar_err_o    (data_gntpar_err_o)
  );

  // ----------------------------------------------------------------------
  // core events
  // ----------------------------------------------------------------------

  debug_event_monitor u_dbg_evt (
    .in_support_if      (in_support_if),
    .rst_n_i            (rst_n_i),
    .fetch_enable_i     (fetch_enable_i),
    .debug_req_i        (debug_req_i),
    .rvfi_valid_i       (rvfi_valid_i),
    .rvfi_dbg_mode_i    (rvfi_dbg_mode_i),
    .rvfi_is_dret_i     (rvfi_is_dret_i),
    .rvfi_trap_i        (rvfi_trap_i),
    .first_fetch_o      (first_fetch_o),
    .first_debug_ins_o  (first_debug_ins_o),
    .recorded_dbg_req_o (recorded_dbg_req_o)
  );

endmodule

// ==== hw/debug_event_monitor.sv ====
`timescale 1ns/1ps

module debug_event_monitor (
  input  logic in_support_if,
  input  logic rst_n_i,

  input  logic fetch_enable_i,
  input  logic debug_req_i,
  input  logic rvfi_valid_i,
  input  logic rvfi_dbg_mode_i,
  input  logic rvfi_is_dret_i,
  input  logic rvfi_trap_i,

  output logic first_fetch_o,
  output logic first_debug_ins_o,
  output logic recorded_dbg_req_o
);

  import core_evt_pkg::*;

  logic       fetch_seen_q;
  dbg_state_e state_q;
  dbg_state_e state_d;
  dbg_win_t   win_q;

  // ----------------------------------------------------------------------
  // core startup
  // ----------------------------------------------------------------------

  assign first_fetch_o = fetch_enable_i & ~fetch_seen_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // first instruction of a debug session
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      NORMAL:    if (rvfi_valid_i && rvfi_dbg_mode_i) state_d = IN_DEBUG;
      IN_DEBUG:  if (rvfi_valid_i && !rvfi_dbg_mode_i) state_d = NORMAL;
      DRET_SEEN: state_d = NORMAL;
      default:   state_d = NORMAL;
    endcase
    // a completed dret ends the session from any state
    if (rvfi_valid_i && rvfi_is_dret_i && !rvfi_trap_i) begin
      state_d = DRET_SEEN;
    end
  end

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      state_q <= NORMAL;
    end else begin
      state_q <= state_d;
    end
  end

  assign first_debug_ins_o = rvfi_valid_i & rvfi_dbg_mode_i & (state_q != IN_DEBUG);

  // ----------------------------------------------------------------------
  // recorded debug request
  // ----------------------------------------------------------------------

  // hold the request for long enough that the core could have taken it
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      recorded_dbg_req_o <= 1'b0;
      win_q              <= '0;
    end else if (debug_req_i) begin
      recorded_dbg_req_o <= 1'b1;
      win_q              <= rvfi_valid_i ? DBG_WIN_RETIRE : DBG_WIN_IDLE;
    end else if (rvfi_valid_i) begin
      if (win_q != '0) begin
        win_q <= win_q - dbg_win_t'(1);
      end else begin
        recorded_dbg_req_o <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/obi_bus_support.sv ====
`timescale 1ns/1ps

module obi_bus_support #(
  parameter int ATTR_W = 1
) (
  input  logic               in_support_if,
  input  logic               rst_n_i,

  input  logic               req_i,
  input  logic               gnt_i,
  input  logic               gntpar_i,
  input  logic               rvalid_i,
  input  logic [ATTR_W-1:0]  attr_i,

  output logic               addr_ph_cont_o,
  output logic               resp_ph_cont_o,
  output obi_pkg::obi_cnt_t  v_addr_ph_cnt_o,
  output logic [ATTR_W-1:0]  attr_o,
  output logic               gntpar_err_o
);

  // ----------------------------------------------------------------------
  // grant parity
  // ----------------------------------------------------------------------

  // gntpar must be the inverse of gnt; one bad cycle taints the whole phase
  logic phase_err;
  logic phase_err_q;

  assign phase_err = req_i & ((gnt_i == gntpar_i) | phase_err_q);

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      phase_err_q <= 1'b0;
    end else if (req_i && !gnt_i) begin
      // still waiting, keep what this phase has seen so far
      phase_err_q <= phase_err;
    end else begin
      phase_err_q <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // phase monitor and response attributes
  // ----------------------------------------------------------------------

  obi_phases_monitor u_phases (
    .in_support_if   (in_support_if),
    .rst_n_i         (rst_n_i),
    .req_i           (req_i),
    .gnt_i           (gnt_i),
    .rvalid_i        (rvalid_i),
    .addr_ph_cont_o  (addr_ph_cont_o),
    .resp_ph_cont_o  (resp_ph_cont_o),
    .v_addr_ph_cnt_o (v_addr_ph_cnt_o)
  );

  req_attribute_fifo #(
    .ATTR_W (ATTR_W)
  ) u_attr_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .gnt_i         (gnt_i),
    .rvalid_i      (rvalid_i),
    .attr_i        (attr_i),
    .attr_o        (attr_o)
  );

  // the error flag pushed at acceptance covers every cycle of the phase
  req_attribute_fifo #(
    .ATTR_W (1)
  ) u_gntpar_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .gnt_i         (gnt_i),
    .rvalid_i      (rvalid_i),
    .attr_i        (phase_err),
    .attr_o        (gntpar_err_o)
  );

endmodule

// ==== hw/req_attribute_fifo.sv ====
`timescale 1ns/1ps

module req_attribute_fifo #(
  parameter int ATTR_W = 1
) (
  input  logic              in_support_if,
  input  logic              rst_n_i,

  input  logic              req_i,
  input  logic              gnt_i,
  input  logic              rvalid_i,

  input  logic [ATTR_W-1:0] attr_i,
  output logic [ATTR_W-1:0] attr_o
);

  import obi_pkg::*;

  // one entry per granted request that still waits for its response
  logic [ATTR_W-1:0] mem_q [MAX_OUTSTANDING];

  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  obi_cnt_t          fill_q;

  logic              push;
  logic              pop;
  logic              empty;

  assign empty = (fill_q == '0);
  assign push  = req_i & gnt_i;
  assign pop   = rvalid_i & ~empty;

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------

  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem_q[wr_ptr_q] <= attr_i;
    end
  end

  // ----------------------------------------------------------------------
  // pointers and fill level
  // ----------------------------------------------------------------------

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + CNT_W'(1);
        2'b01:   fill_q <= fill_q - CNT_W'(1);
        default: fill_q <= fill_q;
      endcase
    end
  end

  // responses come back in order, so the head always belongs to the
  // response seen on rvalid
  assign attr_o = empty ? '0 : mem_q[rd_ptr_q];

endmodule

// ==== hw/obi_phases_monitor.sv ====
`timescale 1ns/1ps

module obi_phases_monitor (
  input  logic               in_support_if,
  input  logic               rst_n_i,

  input  logic               req_i,
  input  logic               gnt_i,
  input  logic               rvalid_i,

  output logic               addr_ph_cont_o,
  output logic               resp_ph_cont_o,
  output obi_pkg::obi_cnt_t  v_addr_ph_cnt_o
);

  import obi_pkg::*;

  logic     accept;
  obi_cnt_t cnt_q;

  // an address phase ends in the cycle where req and gnt are both high
  assign accept = req_i & gnt_i;

  // ----------------------------------------------------------------------
  // address phase continuation
  // ----------------------------------------------------------------------

  // req held without gnt means the same address phase carries on next cycle
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      addr_ph_cont_o <= 1'b0;
    end else begin
      addr_ph_cont_o <= req_i & ~gnt_i;
    end
  end

  // ----------------------------------------------------------------------
  // outstanding counter
  // ----------------------------------------------------------------------

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({accept, rvalid_i})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        // accept and response together leave the count unchanged
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign v_addr_ph_cnt_o = cnt_q;

  // a response is still pending while requests wait and none returns now
  assign resp_ph_cont_o = (cnt_q != '0) & ~rvalid_i;

endmodule

// ==== hw/core_evt_pkg.sv ====
package core_evt_pkg;

  // ----------------------------------------------------------------------
  // recorded debug request
  // ----------------------------------------------------------------------

  // retirements left before a recorded request is dropped
  typedef logic [1:0] dbg_win_t;

  // request arrives together with a retirement
  localparam dbg_win_t DBG_WIN_RETIRE = 2'd1;

  // request arrives in a cycle without a retirement
  localparam dbg_win_t DBG_WIN_IDLE = 2'd2;

  // ----------------------------------------------------------------------
  // first debug instruction tracking
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    NORMAL,
    IN_DEBUG,
    DRET_SEEN
  } dbg_state_e;

endpackage

// ==== hw/obi_pkg.sv ====
package obi_pkg;

  // ----------------------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------------------

  // address and fetch PC width
  localparam int ADDR_W = 32;

  // ----------------------------------------------------------------------
  // outstanding transaction tracking
  // ----------------------------------------------------------------------

  // granted address phases that may wait for a response at once
  localparam int MAX_OUTSTANDING = 4;

  // outstanding count must reach MAX_OUTSTANDING itself, so one extra bit
  localparam int CNT_W = 3;

  // read and write pointers of the attribute FIFO
  localparam int PTR_W = 2;

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------

  // one word of address or PC
  typedef logic [ADDR_W-1:0] obi_addr_t;

  // number of address phases still waiting for a response
  typedef logic [CNT_W-1:0] obi_cnt_t;

endpackage
